//--- rtl/lspc_consts.svh
`ifndef LSPC_CONSTS_SVH
`define LSPC_CONSTS_SVH

// Clocks of CLK_24M per pixel tick
`define LSPC_PIX_DIV 4

// Pixel ticks per line
`define LSPC_LINE_PIXELS 384

// Video mode, 0 is NTSC and 1 is PAL
`define LSPC_VMODE 0

// Lines per frame follow the video mode
`define LSPC_LINES ((`LSPC_VMODE != 0) ? 312 : 264)

// First line of vertical blank
`define LSPC_VBLANK_LINE 240

// VRAM index width, 2K words
`define LSPC_VRAM_AW 11

`endif

//--- rtl/lspcPkg.sv
package lspcPkg;

	// Register index, same encoding as cpuAddr
	typedef enum logic [2:0] {
		VramAddr  = 3'd0,
		VramData  = 3'd1,
		VramMod   = 3'd2,
		LspcMode  = 3'd3,
		TimerHigh = 3'd4,
		TimerLow  = 3'd5,
		IrqAck    = 3'd6,
		TimerStop = 3'd7
	} lspcReg_e;

	// Mode word as written by the CPU
	typedef struct packed {
		logic [7:0] aaSpeed;
		logic       timerReloadZero;
		logic       timerReloadFrame;
		logic       timerLoadOnLow;
		logic       timerIrqEn;
		logic       aaDisable;
		logic [2:0] rsvd;
	} lspcModeCfg_s;

	// Same address as read back
	typedef struct packed {
		logic [8:0] rasterLine;
		logic [2:0] zero;
		logic       vmode;
		logic [2:0] aaCount;
	} lspcModeStat_s;

	typedef union packed {
		lspcModeCfg_s  cfg;
		lspcModeStat_s stat;
	} lspcMode_u;

endpackage

//--- rtl/lspcRegWrite.sv
`timescale 1ns/1ns

module lspcRegWrite
	import lspcPkg::*;
(
	input  logic         CLK_24M,
	input  logic         rstN,
	input  logic [2:0]   cpuAddr,
	input  logic [15:0]  cpuWrData,
	input  logic         cpuWe,
	input  logic         cpuRe,
	output logic         wrVramAddr,
	output logic         wrVramData,
	output logic         wrTimerHigh,
	output logic         wrTimerLow,
	output logic         wrIrqAck,
	output logic [15:0]  wrData,
	output lspcModeCfg_s modeCfg,
	output logic [15:0]  vramMod
);

	lspcReg_e  regSel;
	lspcMode_u modeWr;
	logic      wrVramMod;
	logic      wrLspcMode;

	assign regSel = lspcReg_e'(cpuAddr);
	assign modeWr = cpuWrData;
	assign wrData = cpuWrData;

	// Write decoder, one pulse per register
	always_comb
	begin
		wrVramAddr = 1'b0;
		wrVramData = 1'b0;
		wrVramMod = 1'b0;
		wrLspcMode = 1'b0;
		wrTimerHigh = 1'b0;
		wrTimerLow = 1'b0;
		wrIrqAck = 1'b0;
		if (cpuWe)
		begin
			case (regSel)
				VramAddr:  wrVramAddr = 1'b1;
				VramData:  wrVramData = 1'b1;
				VramMod:   wrVramMod = 1'b1;
				LspcMode:  wrLspcMode = 1'b1;
				TimerHigh: wrTimerHigh = 1'b1;
				TimerLow:  wrTimerLow = 1'b1;
				IrqAck:    wrIrqAck = 1'b1;
				// Timer stop has no effect here
				TimerStop: ;
				default:   ;
			endcase
		end
	end

	always_ff @(posedge CLK_24M)
	begin
		if (!rstN)
		begin
			modeCfg <= '0;
			vramMod <= '0;
		end
		else
		begin
			if (wrLspcMode)
				modeCfg <= modeWr.cfg;
			if (wrVramMod)
				vramMod <= cpuWrData;
		end
	end

	// Bus rule: read and write strobes are exclusive
	assert property (@(posedge CLK_24M) disable iff (!rstN) !(cpuWe && cpuRe))
		else $error("cpuWe and cpuRe asserted in the same cycle");

endmodule

//--- rtl/lspcVramPort.sv
`timescale 1ns/1ns
`include "lspc_consts.svh"

module lspcVramPort (
	input  logic        CLK_24M,
	input  logic        rstN,
	input  logic        wrVramAddr,
	input  logic        wrVramData,
	input  logic [15:0] wrData,
	input  logic [15:0] vramMod,
	output logic [15:0] vramAddr,
	output logic [15:0] vramRdData
);

	localparam int VramWords = 2 ** `LSPC_VRAM_AW;

	logic [15:0] vram [VramWords];
	logic [15:0] addrAutoInc;
	logic [15:0] addrNext;
	logic        addrLoad;
	logic [`LSPC_VRAM_AW-1:0] vramIdx;

	// Only the low bits index the shortened array
	assign vramIdx = vramAddr[`LSPC_VRAM_AW-1:0];

	// Modulo add wraps at 16 bits
	assign addrAutoInc = vramAddr + vramMod;

	// New address from the CPU, or step after a data write
	assign addrNext = wrVramAddr ? wrData : addrAutoInc;
	assign addrLoad = wrVramAddr || wrVramData;

	always_ff @(posedge CLK_24M)
	begin
		if (!rstN)
			vramAddr <= '0;
		else if (addrLoad)
			vramAddr <= addrNext;
	end

	// Data lands at the address before the step
	always_ff @(posedge CLK_24M)
	begin
		if (wrVramData)
			vram[vramIdx] <= wrData;
	end

	// Async read, the read mux registers it
	assign vramRdData = vram[vramIdx];

	// Address load and data write come from different CPU cycles
	assert property (@(posedge CLK_24M) disable iff (!rstN) !(wrVramAddr && wrVramData))
		else $error("VRAM address and data write pulses coincide");

endmodule

//--- rtl/lspcRasterTimer.sv
`timescale 1ns/1ns
`include "lspc_consts.svh"

module lspcRasterTimer
	import lspcPkg::*;
(
	input  logic         CLK_24M,
	input  logic         rstN,
	input  logic         wrTimerHigh,
	input  logic         wrTimerLow,
	input  logic         wrIrqAck,
	input  logic [15:0]  wrData,
	input  lspcModeCfg_s modeCfg,
	output logic [8:0]   rasterLine,
	output logic         frameStart,
	output logic [1:0]   ipl
);

	localparam int DivW = $clog2(`LSPC_PIX_DIV);

	logic [DivW-1:0] pixDiv;
	logic            pixTick;
	logic [8:0]      pixelCnt;
	logic            lineEnd;
	logic [15:0]     reloadHigh;
	logic [15:0]     reloadLow;
	logic [31:0]     reloadVal;
	logic [31:0]     timerCnt;
	logic            timerExpire;
	logic            resetPend;
	logic            timerPend;
	logic            vblankPend;

	// Pixel tick every fourth clock
	assign pixTick = (pixDiv == DivW'(`LSPC_PIX_DIV - 1));
	assign lineEnd = pixTick && (pixelCnt == 9'(`LSPC_LINE_PIXELS - 1));

	always_ff @(posedge CLK_24M)
	begin
		if (!rstN)
		begin
			pixDiv <= '0;
			pixelCnt <= '0;
			rasterLine <= '0;
		end
		else
		begin
			pixDiv <= pixTick ? '0 : pixDiv + 1'b1;
			if (lineEnd)
			begin
				pixelCnt <= '0;
				if (rasterLine == 9'(`LSPC_LINES - 1))
					rasterLine <= '0;
				else
					rasterLine <= rasterLine + 1'b1;
			end
			else if (pixTick)
				pixelCnt <= pixelCnt + 1'b1;
		end
	end

	// First tick of the vblank line
	assign frameStart = pixTick && (pixelCnt == '0) &&
		(rasterLine == 9'(`LSPC_VBLANK_LINE));

	always_ff @(posedge CLK_24M)
	begin
		if (wrTimerHigh)
			reloadHigh <= wrData;
		if (wrTimerLow)
			reloadLow <= wrData;
	end

	assign reloadVal = {reloadHigh, reloadLow};
	assign timerExpire = pixTick && modeCfg.timerIrqEn && (timerCnt == '0);

	// CPU load beats frame reload beats counting
	always_ff @(posedge CLK_24M)
	begin
		if (!rstN)
			timerCnt <= '0;
		else if (wrTimerLow && modeCfg.timerLoadOnLow)
			timerCnt <= {reloadHigh, wrData};
		else if (frameStart && modeCfg.timerReloadFrame)
			timerCnt <= reloadVal;
		else if (pixTick && modeCfg.timerIrqEn)
		begin
			if (timerCnt == '0 && modeCfg.timerReloadZero)
				timerCnt <= reloadVal;
			else
				timerCnt <= timerCnt - 1'b1;
		end
	end

	// Pending flags, a new event wins over an ack in the same cycle
	always_ff @(posedge CLK_24M)
	begin
		if (!rstN)
		begin
			resetPend <= 1'b1;
			timerPend <= 1'b0;
			vblankPend <= 1'b0;
		end
		else
		begin
			if (wrIrqAck && wrData[0])
				resetPend <= 1'b0;
			if (timerExpire)
				timerPend <= 1'b1;
			else if (wrIrqAck && wrData[1])
				timerPend <= 1'b0;
			if (frameStart)
				vblankPend <= 1'b1;
			else if (wrIrqAck && wrData[2])
				vblankPend <= 1'b0;
		end
	end

	always_comb
	begin
		if (resetPend)
			ipl = 2'd3;
		else if (timerPend)
			ipl = 2'd2;
		else if (vblankPend)
			ipl = 2'd1;
		else
			ipl = 2'd0;
	end

	assert property (@(posedge CLK_24M) disable iff (!rstN) rasterLine < 9'(`LSPC_LINES))
		else $error("rasterLine out of range: %0d", rasterLine);

endmodule

//--- rtl/lspcAutoAnim.sv
`timescale 1ns/1ns

module lspcAutoAnim (
	input  logic       CLK_24M,
	input  logic       rstN,
	input  logic       frameStart,
	input  logic [7:0] aaSpeed,
	input  logic       aaDisable,
	output logic [2:0] aaCount
);

	logic [7:0] frameCnt;
	logic       frameStep;

	assign frameStep = frameStart && !aaDisable;

	// Tile advances every aaSpeed+1 frames
	always_ff @(posedge CLK_24M)
	begin
		if (!rstN)
		begin
			frameCnt <= '0;
			aaCount <= '0;
		end
		else if (frameStep)
		begin
			if (frameCnt == aaSpeed)
			begin
				frameCnt <= '0;
				aaCount <= aaCount + 1'b1;
			end
			else
				frameCnt <= frameCnt + 1'b1;
		end
	end

endmodule

//--- rtl/lspcReadMux.sv
`timescale 1ns/1ns
`include "lspc_consts.svh"

module lspcReadMux
	import lspcPkg::*;
(
	input  logic        CLK_24M,
	input  logic        rstN,
	input  logic [2:0]  cpuAddr,
	input  logic        cpuRe,
	input  logic [15:0] vramRdData,
	input  logic [15:0] vramMod,
	input  logic [8:0]  rasterLine,
	input  logic [2:0]  aaCount,
	output logic [15:0] cpuRdData,
	output logic        cpuRdValid
);

	lspcReg_e    regSel;
	lspcMode_u   modeRd;
	logic [15:0] rdSel;

	assign regSel = lspcReg_e'(cpuAddr);

	// Status view of the mode address
	always_comb
	begin
		modeRd.stat.rasterLine = rasterLine;
		modeRd.stat.zero = '0;
		modeRd.stat.vmode = (`LSPC_VMODE != 0);
		modeRd.stat.aaCount = aaCount;
	end

	always_comb
	begin
		case (regSel)
			VramAddr, VramData: rdSel = vramRdData;
			VramMod:            rdSel = vramMod;
			LspcMode:           rdSel = modeRd;
			default:            rdSel = '0;
		endcase
	end

	always_ff @(posedge CLK_24M)
	begin
		if (!rstN)
			cpuRdValid <= 1'b0;
		else
			cpuRdValid <= cpuRe;
	end

	// Word held until the next read
	always_ff @(posedge CLK_24M)
	begin
		if (cpuRe)
			cpuRdData <= rdSel;
	end

endmodule

//--- rtl/lspcTop.sv
`timescale 1ns/1ns

module lspcTop
	import lspcPkg::*;
(
	input  logic        CLK_24M,
	input  logic        rstN,
	input  logic [2:0]  cpuAddr,
	input  logic [15:0] cpuWrData,
	input  logic        cpuWe,
	input  logic        cpuRe,
	output logic [15:0] cpuRdData,
	output logic        cpuRdValid,
	output logic [1:0]  ipl
);

	logic         wrVramAddr;
	logic         wrVramData;
	logic         wrTimerHigh;
	logic         wrTimerLow;
	logic         wrIrqAck;
	logic [15:0]  wrData;
	lspcModeCfg_s modeCfg;
	logic [15:0]  vramMod;
	logic [15:0]  vramRdData;
	logic [8:0]   rasterLine;
	logic         frameStart;
	logic [2:0]   aaCount;

	lspcRegWrite i_lspcRegWrite (
		.CLK_24M     (CLK_24M),
		.rstN        (rstN),
		.cpuAddr     (cpuAddr),
		.cpuWrData   (cpuWrData),
		.cpuWe       (cpuWe),
		.cpuRe       (cpuRe),
		.wrVramAddr  (wrVramAddr),
		.wrVramData  (wrVramData),
		.wrTimerHigh (wrTimerHigh),
		.wrTimerLow  (wrTimerLow),
		.wrIrqAck    (wrIrqAck),
		.wrData      (wrData),
		.modeCfg     (modeCfg),
		.vramMod     (vramMod)
	);

	lspcVramPort i_lspcVramPort (
		.CLK_24M    (CLK_24M),
		.rstN       (rstN),
		.wrVramAddr (wrVramAddr),
		.wrVramData (wrVramData),
		.wrData     (wrData),
		.vramMod    (vramMod),
		.vramAddr   (),
		.vramRdData (vramRdData)
	);

	lspcRasterTimer i_lspcRasterTimer (
		.CLK_24M     (CLK_24M),
		.rstN        (rstN),
		.wrTimerHigh (wrTimerHigh),
		.wrTimerLow  (wrTimerLow),
		.wrIrqAck    (wrIrqAck),
		.wrData      (wrData),
		.modeCfg     (modeCfg),
		.rasterLine  (rasterLine),
		.frameStart  (frameStart),
		.ipl         (ipl)
	);

	lspcAutoAnim i_lspcAutoAnim (
		.CLK_24M    (CLK_24M),
		.rstN       (rstN),
		.frameStart (frameStart),
		.aaSpeed    (modeCfg.aaSpeed),
		.aaDisable  (modeCfg.aaDisable),
		.aaCount    (aaCount)
	);

	lspcReadMux i_lspcReadMux (
		.CLK_24M    (CLK_24M),
		.rstN       (rstN),
		.cpuAddr    (cpuAddr),
		.cpuRe      (cpuRe),
		.vramRdData (vramRdData),
		.vramMod    (vramMod),
		.rasterLine (rasterLine),
		.aaCount    (aaCount),
		.cpuRdData  (cpuRdData),
		.cpuRdValid (cpuRdValid)
	);

endmodule

//--- testbench/tbClock.sv
`timescale 1ns/1ns

module tbClock #(
	parameter int PeriodNs = 100,
	parameter int ResetCycles = 8
) (
	output logic CLK_24M,
	output logic rstN
);

	initial
	begin
		CLK_24M = 1'b0;
		forever
			#(PeriodNs / 2) CLK_24M = ~CLK_24M;
	end

	// Release on a falling edge, clear of the sampling edge
	initial
	begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge CLK_24M);
		@(negedge CLK_24M);
		rstN = 1'b1;
	end

endmodule

//--- testbench/lspcChecker.sv
`timescale 1ns/1ns
`include "lspc_consts.svh"

module lspcChecker
	import lspcPkg::*;
(
	input  logic        CLK_24M,
	input  logic        rstN,
	input  int          testId,
	input  logic        cpuRe,
	input  logic [15:0] cpuRdData,
	input  logic        cpuRdValid,
	input  logic [1:0]  ipl,
	input  logic [15:0] expData,
	input  logic [15:0] expMask,
	input  logic        expStatus,
	input  logic        iplChk,
	input  logic [1:0]  expIpl,
	output int          errCount,
	output int          checkCount
);

	logic      rdPending;
	lspcMode_u rdView;

	// Status reads decode through the read view of the mode word
	assign rdView = cpuRdData;

	initial
	begin
		errCount = 0;
		checkCount = 0;
	end

	task automatic compareRead();
		checkCount++;
		if ((cpuRdData & expMask) !== (expData & expMask))
		begin
			$display("Error test %0d cpuRdData expected 0x%h got 0x%h mask 0x%h",
				testId, expData, cpuRdData, expMask);
			errCount++;
		end
		if (expStatus && !(rdView.stat.rasterLine < 9'(`LSPC_LINES)))
		begin
			$display("Error test %0d rasterLine 0x%h not below 0x%h",
				testId, rdView.stat.rasterLine, 9'(`LSPC_LINES));
			errCount++;
		end
	endtask

	task automatic compareIpl();
		checkCount++;
		if (ipl !== expIpl)
		begin
			$display("Error test %0d ipl expected 0x%h got 0x%h", testId, expIpl, ipl);
			errCount++;
		end
	endtask

	// Response due exactly one cycle after the strobe
	always @(posedge CLK_24M)
	begin
		if (!rstN)
			rdPending <= 1'b0;
		else
		begin
			rdPending <= cpuRe;
			if (rdPending && !cpuRdValid)
			begin
				$display("Test %0d: a read strobe got no cpuRdValid on the next cycle", testId);
				errCount++;
			end
			if (cpuRdValid && !rdPending)
			begin
				$display("Test %0d: cpuRdValid pulsed without a read strobe", testId);
				errCount++;
			end
			if (cpuRdValid)
				compareRead();
			if (iplChk)
				compareIpl();
		end
	end

endmodule

//--- testbench/lspcTb.sv
`timescale 1ns/1ns
`include "lspc_consts.svh"

module lspcTb
	import lspcPkg::*;
();

	localparam int FrameCycles = `LSPC_PIX_DIV * `LSPC_LINE_PIXELS * `LSPC_LINES;
	localparam int FrameWait = FrameCycles + 16;
	localparam int TimerReload = 100;
	localparam int TimerWait = (TimerReload + 1) * `LSPC_PIX_DIV + 8;
	// Three vblank waits plus the short tests, with a frame of margin
	localparam int TimeoutCycles = 5 * FrameCycles;
	localparam logic [15:0] StatusMask = 16'h007F;
	localparam int VramWords = 2 ** `LSPC_VRAM_AW;

	logic        CLK_24M;
	logic        rstN;
	logic [2:0]  cpuAddr;
	logic [15:0] cpuWrData;
	logic        cpuWe;
	logic        cpuRe;
	logic [15:0] cpuRdData;
	logic        cpuRdValid;
	logic [1:0]  ipl;
	logic [15:0] expData;
	logic [15:0] expMask;
	logic        expStatus;
	logic        iplChk;
	logic [1:0]  expIpl;
	int          testId;
	int          errCount;
	int          checkCount;
	int          errAtStart;
	int          testsFailed;
	int          seed;
	int          cycleCount;
	logic [15:0] modelVram [VramWords];
	logic [15:0] modelAddr;
	logic [15:0] modelMod;
	logic [15:0] modelMode;
	logic [7:0]  modelFrameCnt;
	logic [2:0]  modelAa;
	logic [15:0] addrList [32];
	logic [15:0] modBase;

	tbClock i_tbClock (.CLK_24M(CLK_24M), .rstN(rstN));

	lspcTop i_lspcTop (
		.CLK_24M    (CLK_24M),
		.rstN       (rstN),
		.cpuAddr    (cpuAddr),
		.cpuWrData  (cpuWrData),
		.cpuWe      (cpuWe),
		.cpuRe      (cpuRe),
		.cpuRdData  (cpuRdData),
		.cpuRdValid (cpuRdValid),
		.ipl        (ipl)
	);

	lspcChecker i_lspcChecker (
		.CLK_24M    (CLK_24M),
		.rstN       (rstN),
		.testId     (testId),
		.cpuRe      (cpuRe),
		.cpuRdData  (cpuRdData),
		.cpuRdValid (cpuRdValid),
		.ipl        (ipl),
		.expData    (expData),
		.expMask    (expMask),
		.expStatus  (expStatus),
		.iplChk     (iplChk),
		.expIpl     (expIpl),
		.errCount   (errCount),
		.checkCount (checkCount)
	);

	// Expected read word from the model state
	function automatic logic [15:0] modelRead(input logic [2:0] addr);
		case (lspcReg_e'(addr))
			VramAddr, VramData: modelRead = modelVram[modelAddr[`LSPC_VRAM_AW-1:0]];
			VramMod:            modelRead = modelMod;
			LspcMode:           modelRead = {9'd0, 3'd0, 1'(`LSPC_VMODE != 0), modelAa};
			default:            modelRead = 16'h0000;
		endcase
	endfunction

	// Frame divider and tile count at each vblank
	task automatic modelFrame();
		if (!modelMode[3])
		begin
			if (modelFrameCnt == modelMode[15:8])
			begin
				modelFrameCnt = '0;
				modelAa = modelAa + 1'b1;
			end
			else
				modelFrameCnt = modelFrameCnt + 1'b1;
		end
	endtask

	task automatic writeReg(input logic [2:0] addr, input logic [15:0] data);
		@(negedge CLK_24M);
		cpuAddr = addr;
		cpuWrData = data;
		cpuWe = 1'b1;
		@(negedge CLK_24M);
		cpuWe = 1'b0;
		case (lspcReg_e'(addr))
			VramAddr: modelAddr = data;
			VramData:
			begin
				modelVram[modelAddr[`LSPC_VRAM_AW-1:0]] = data;
				modelAddr = modelAddr + modelMod;
			end
			VramMod:  modelMod = data;
			LspcMode: modelMode = data;
			default:  ;
		endcase
	endtask

	// Fixed one-cycle response, compared by the checker on the next rising edge
	task automatic readReg(input logic [2:0] addr, input logic [15:0] mask);
		@(negedge CLK_24M);
		cpuAddr = addr;
		cpuRe = 1'b1;
		expData = modelRead(addr);
		expMask = mask;
		expStatus = (addr == 3'(LspcMode));
		@(negedge CLK_24M);
		cpuRe = 1'b0;
		@(negedge CLK_24M);
	endtask

	task automatic checkIpl(input logic [1:0] value);
		@(negedge CLK_24M);
		expIpl = value;
		iplChk = 1'b1;
		@(negedge CLK_24M);
		iplChk = 1'b0;
	endtask

	task automatic waitIpl(input logic [1:0] value, input int limit);
		int n;
		n = 0;
		while (ipl !== value && n < limit)
		begin
			@(negedge CLK_24M);
			n++;
		end
		checkIpl(value);
	endtask

	task automatic startTest(input int num);
		testId = num;
		errAtStart = errCount;
	endtask

	task automatic finishTest(input string name);
		if (errCount == errAtStart)
			$display("Test %0d %s: passed", testId, name);
		else
		begin
			$display("Test %0d %s: FAILED with %0d errors", testId, name, errCount - errAtStart);
			testsFailed++;
		end
	endtask

	initial
	begin
		cycleCount = 0;
		while (cycleCount < TimeoutCycles)
		begin
			@(posedge CLK_24M);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, the run did not complete", cycleCount);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		cpuAddr = '0;
		cpuWrData = '0;
		cpuWe = 1'b0;
		cpuRe = 1'b0;
		expData = '0;
		expMask = '0;
		expStatus = 1'b0;
		iplChk = 1'b0;
		expIpl = '0;
		testId = 0;
		testsFailed = 0;
		seed = 73;
		modelAddr = '0;
		modelMod = '0;
		modelMode = '0;
		modelFrameCnt = '0;
		modelAa = '0;
		@(posedge rstN);

		startTest(1);
		checkIpl(2'd3);
		writeReg(IrqAck, 16'h0001);
		checkIpl(2'd0);
		readReg(LspcMode, StatusMask);
		finishTest("reset state");

		startTest(2);
		modBase = 16'($random(seed));
		writeReg(VramMod, modBase | 16'h0001);
		writeReg(VramAddr, 16'($random(seed)));
		for (int k = 0; k < 32; k++)
		begin
			addrList[k] = modelAddr;
			writeReg(VramData, 16'($random(seed)));
		end
		for (int k = 0; k < 32; k++)
		begin
			writeReg(VramAddr, addrList[k]);
			readReg(k[0] ? 3'(VramData) : 3'(VramAddr), 16'hFFFF);
		end
		finishTest("VRAM modulo writes");

		startTest(3);
		readReg(VramMod, 16'hFFFF);
		for (int a = 4; a < 8; a++)
			readReg(3'(a), 16'hFFFF);
		finishTest("modulo and zero reads");

		startTest(4);
		// Load on low half only, counter held until enabled
		writeReg(LspcMode, 16'h0020);
		writeReg(TimerHigh, 16'h0000);
		writeReg(TimerLow, 16'(TimerReload));
		// Enable, load on low half, reload at zero
		writeReg(LspcMode, 16'h00B0);
		checkIpl(2'd0);
		waitIpl(2'd2, TimerWait);
		writeReg(IrqAck, 16'h0002);
		checkIpl(2'd0);
		waitIpl(2'd2, TimerWait);
		writeReg(LspcMode, 16'h0000);
		writeReg(IrqAck, 16'h0002);
		checkIpl(2'd0);
		finishTest("timer interrupt");

		startTest(5);
		writeReg(LspcMode, 16'h0000);
		for (int f = 0; f < 2; f++)
		begin
			waitIpl(2'd1, FrameWait);
			modelFrame();
			readReg(LspcMode, StatusMask);
			writeReg(IrqAck, 16'h0004);
			checkIpl(2'd0);
		end
		finishTest("vblank and auto-animation");

		startTest(6);
		writeReg(LspcMode, 16'h0008);
		readReg(LspcMode, StatusMask);
		waitIpl(2'd1, FrameWait);
		modelFrame();
		readReg(LspcMode, StatusMask);
		writeReg(IrqAck, 16'h0004);
		checkIpl(2'd0);
		finishTest("auto-animation disabled");

		$display("Tests 6, failed %0d, checks %0d, errors %0d", testsFailed, checkCount, errCount);
		if (errCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+rtl
rtl/lspcPkg.sv
rtl/lspcRegWrite.sv
rtl/lspcVramPort.sv
rtl/lspcRasterTimer.sv
rtl/lspcAutoAnim.sv
rtl/lspcReadMux.sv
rtl/lspcTop.sv
testbench/tbClock.sv
testbench/lspcChecker.sv
testbench/lspcTb.sv

//--- Bender.yml
package:
  name: lspc

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lspcPkg.sv
      - rtl/lspcRegWrite.sv
      - rtl/lspcVramPort.sv
      - rtl/lspcRasterTimer.sv
      - rtl/lspcAutoAnim.sv
      - rtl/lspcReadMux.sv
      - rtl/lspcTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tbClock.sv
      - testbench/lspcChecker.sv
      - testbench/lspcTb.sv
